//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_video_top
FILELIST  = arcade_video.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- arcade_video.f
arcade_video_pkg.sv
dpram.sv
cpu_port_decode.sv
tile_fetch.sv
line_doubler.sv
video_top.sv
tb_video_top.sv

//--- arcade_video_pkg.sv
// Shared types, CPU address map and sync timing for the tile video subsystem.
// Every RTL file and the testbench pull these in with a wildcard import.

package arcade_video_pkg;

	typedef logic [7:0] byte_t;

	// Palette word and output colour, red in the top bits
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} rgb333_t;

	localparam int CPU_AW = 13;

	typedef struct packed {
		logic [CPU_AW-1:0] addr;
		byte_t             wdata;
		logic              ce;
		logic              we;
	} cpu_bus_t;

	typedef struct packed {
		rgb333_t rgb;
		logic    de;
		logic    hsync;
		logic    vsync;
	} video_out_t;

	// RAM address widths, one word per CPU address except the palette
	localparam int MAP_AW = 10;
	localparam int PAT_AW = 11;
	localparam int PAL_AW = 6;

	localparam logic [CPU_AW-1:0] MAP_BASE = 13'h0000;
	localparam logic [CPU_AW-1:0] PAT_BASE = 13'h0800;
	localparam logic [CPU_AW-1:0] PAL_BASE = 13'h1000;

	// Port A strobe sets produced by the CPU decoder
	typedef struct packed {
		logic [MAP_AW-1:0] addr;
		byte_t             data;
		logic              ce;
		logic              we;
	} map_port_t;

	typedef struct packed {
		logic [PAT_AW-1:0] addr;
		byte_t             data;
		logic              ce;
		logic              we;
	} pat_port_t;

	typedef struct packed {
		logic [PAL_AW-1:0] addr;
		rgb333_t           data;
		logic              ce;
		logic              we;
	} pal_port_t;

	// Sync placement, counted from the end of the active line or frame
	localparam int HSYNC_OFFSET = 8;
	localparam int HSYNC_WIDTH  = 8;
	localparam int VSYNC_OFFSET = 2;
	localparam int VSYNC_LINES  = 2;

endpackage

//--- cpu_port_decode.sv
// CPU side of the video memories: splits the strobe bus into the port A
// strobes of the map, pattern and palette RAMs and returns the read data.

module cpu_port_decode
	import arcade_video_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  cpu_bus_t  cpu,
	input  byte_t     map_q,
	input  byte_t     pat_q,
	input  rgb333_t   pal_q,
	output map_port_t map_port,
	output pat_port_t pat_port,
	output pal_port_t pal_port,
	output byte_t     cpu_rdata
);

	logic in_map;
	logic in_pat;
	logic in_pal;
	logic pal_odd;

	// Red bit 2 of the next palette entry, set by the even address write
	logic red_hi;

	// Region and parity of the read issued in the previous cycle
	logic rd_map;
	logic rd_pat;
	logic rd_pal;
	logic rd_odd;

	assign in_map  = cpu.addr[CPU_AW-1:MAP_AW] == MAP_BASE[CPU_AW-1:MAP_AW];
	assign in_pat  = cpu.addr[CPU_AW-1:PAT_AW] == PAT_BASE[CPU_AW-1:PAT_AW];
	assign in_pal  = cpu.addr[CPU_AW-1:PAL_AW+1] == PAL_BASE[CPU_AW-1:PAL_AW+1];
	assign pal_odd = cpu.addr[0];

	always_comb begin
		map_port.addr = cpu.addr[MAP_AW-1:0];
		map_port.data = cpu.wdata;
		map_port.ce   = cpu.ce && in_map;
		map_port.we   = cpu.we;

		pat_port.addr = cpu.addr[PAT_AW-1:0];
		pat_port.data = cpu.wdata;
		pat_port.ce   = cpu.ce && in_pat;
		pat_port.we   = cpu.we;

		// Two addresses per entry, so the entry index starts at bit 1
		pal_port.addr = cpu.addr[PAL_AW:1];
		pal_port.data = rgb333_t'({red_hi, cpu.wdata});
		pal_port.ce   = cpu.ce && in_pal;
		pal_port.we   = cpu.we && pal_odd;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			red_hi <= 1'b0;
		end else if (cpu.ce && cpu.we && in_pal && !pal_odd) begin
			red_hi <= cpu.wdata[0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_map <= 1'b0;
			rd_pat <= 1'b0;
			rd_pal <= 1'b0;
			rd_odd <= 1'b0;
		end else begin
			rd_map <= cpu.ce && !cpu.we && in_map;
			rd_pat <= cpu.ce && !cpu.we && in_pat;
			rd_pal <= cpu.ce && !cpu.we && in_pal;
			rd_odd <= pal_odd;
		end
	end

	// Data only shows in the cycle after a read, zero the rest of the time
	always_comb begin
		cpu_rdata = '0;
		if (rd_map) begin
			cpu_rdata = map_q;
		end else if (rd_pat) begin
			cpu_rdata = pat_q;
		end else if (rd_pal) begin
			if (rd_odd) begin
				cpu_rdata = pal_q[7:0];
			end else begin
				cpu_rdata = {7'b0, pal_q.red[2]};
			end
		end
	end

endmodule

//--- dpram.sv
// Generic true dual-port block RAM with one clock.
// Depth comes from ADDR_W and the word from the word_t type parameter.

module dpram #(
	parameter int  ADDR_W = 8,
	parameter type word_t = logic [7:0]
) (
	input  logic              clk,

	input  logic [ADDR_W-1:0] address_a,
	input  word_t             data_a,
	input  logic              enable_a,
	input  logic              wren_a,
	output word_t             q_a,

	input  logic [ADDR_W-1:0] address_b,
	input  word_t             data_b,
	input  logic              enable_b,
	input  logic              wren_b,
	output word_t             q_b
);

	word_t mem [2**ADDR_W];

	// Both ports read one cycle late and see the old word on a write to the
	// same address. If both ports write one address at once, port B wins
	always_ff @(posedge clk) begin
		if (enable_a) begin
			q_a <= mem[address_a];
			if (wren_a) begin
				mem[address_a] <= data_a;
			end
		end
		if (enable_b) begin
			q_b <= mem[address_b];
			if (wren_b) begin
				mem[address_b] <= data_b;
			end
		end
	end

endmodule

//--- line_doubler.sv
// Scan doubler: stores each source line in one half of a line RAM and plays
// the other half twice at clock rate, turning 15 kHz lines into 31 kHz.

module line_doubler
	import arcade_video_pkg::*;
#(
	parameter int H_ACTIVE = 256,
	parameter int H_TOTAL  = 384
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       pix_ce,
	input  video_out_t src_out,
	output video_out_t vid_out
);

	localparam int LW = $clog2(H_ACTIVE);
	localparam int XW = $clog2(H_TOTAL);

	logic [LW-1:0] wr_x;
	logic          wr_bank;
	logic          wr_en;
	logic          seen_de;
	logic          src_hs_d;
	logic          swap;

	// State of the line being played back
	logic          line_de;
	logic          line_vs;
	logic          running;

	logic [XW-1:0] out_x;
	logic          out_de;
	logic          out_hs;
	logic          ctl_de;
	logic          ctl_hs;
	logic          ctl_vs;
	rgb333_t       rd_q;

	// A source line ends at its hsync, which comes after the active pixels
	assign swap  = pix_ce && src_out.hsync && !src_hs_d;
	assign wr_en = pix_ce && src_out.de;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_x     <= '0;
			wr_bank  <= 1'b0;
			seen_de  <= 1'b0;
			src_hs_d <= 1'b0;
			line_de  <= 1'b0;
			line_vs  <= 1'b0;
			running  <= 1'b0;
		end else if (pix_ce) begin
			src_hs_d <= src_out.hsync;
			if (swap) begin
				wr_x    <= '0;
				wr_bank <= !wr_bank;
				seen_de <= 1'b0;
				line_de <= seen_de;
				line_vs <= src_out.vsync;
				running <= 1'b1;
			end else if (src_out.de) begin
				wr_x    <= wr_x + 1'b1;
				seen_de <= 1'b1;
			end
		end
	end

	// Output h counter, realigned on every line swap. A source line lasts
	// exactly two wraps, so the realign only matters for the first one
	always_ff @(posedge clk) begin
		if (reset) begin
			out_x <= '0;
		end else if (swap || out_x == XW'(H_TOTAL - 1)) begin
			out_x <= '0;
		end else begin
			out_x <= out_x + 1'b1;
		end
	end

	assign out_de = line_de && (out_x < H_ACTIVE);
	assign out_hs = running && (out_x >= H_ACTIVE + HSYNC_OFFSET) &&
		(out_x < H_ACTIVE + HSYNC_OFFSET + HSYNC_WIDTH);

	// Delay control one clock to meet the RAM read data
	always_ff @(posedge clk) begin
		if (reset) begin
			ctl_de <= 1'b0;
			ctl_hs <= 1'b0;
			ctl_vs <= 1'b0;
		end else begin
			ctl_de <= out_de;
			ctl_hs <= out_hs;
			ctl_vs <= line_vs;
		end
	end

	dpram #(
		.ADDR_W (LW + 1),
		.word_t (rgb333_t)
	) line_ram (
		.clk       (clk),
		.address_a ({wr_bank, wr_x}),
		.data_a    (src_out.rgb),
		.enable_a  (wr_en),
		.wren_a    (wr_en),
		.q_a       (),
		.address_b ({!wr_bank, LW'(out_x)}),
		.data_b    ('0),
		.enable_b  (1'b1),
		.wren_b    (1'b0),
		.q_b       (rd_q)
	);

	assign vid_out = '{
		rgb:   ctl_de ? rd_q : '0,
		de:    ctl_de,
		hsync: ctl_hs,
		vsync: ctl_vs
	};

endmodule

//--- tb_video_top.sv
// Testbench for the tile video subsystem. Loads the memories over the CPU port,
// checks readback, then scans the doubled video output against a memory model.

module tb_video_top
	import arcade_video_pkg::*;
();

	localparam int H_ACTIVE = 64;
	localparam int H_TOTAL  = 96;
	localparam int V_ACTIVE = 32;
	localparam int V_TOTAL  = 40;

	localparam int MAP_WORDS   = 1024;
	localparam int PAT_WORDS   = 2048;
	localparam int PAL_ENTRIES = 64;
	localparam logic [CPU_AW-1:0] MAP_END = 13'h0400;
	localparam logic [CPU_AW-1:0] PAT_END = 13'h1000;
	localparam logic [CPU_AW-1:0] PAL_END = 13'h1080;
	localparam int LB_W = $clog2(H_ACTIVE);

	// Five doubled frames plus one clock per CPU access and the quiet check
	localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * 2;
	localparam int LOAD_CLKS  = 2 * (MAP_WORDS + PAT_WORDS + 2 * PAL_ENTRIES) + H_TOTAL + 64;
	localparam int MAX_CYCLES = 5 * FRAME_CLKS + LOAD_CLKS;

	logic       clk = 1'b0;
	logic       reset;
	cpu_bus_t   cpu;
	byte_t      cpu_rdata;
	video_out_t vid_out;

	int seed;
	int cycles = 0;

	// Model of the three memories, updated at the edge where the DUT takes a write
	byte_t    map_m [MAP_WORDS];
	byte_t    pat_m [PAT_WORDS];
	rgb333_t  pal_m [PAL_ENTRIES];
	logic     red_hi_m = 1'b0;
	cpu_bus_t taken = '0;

	int      line_cnt = 0;
	int      pix_x = 0;
	int      hs_cnt = 0;
	logic    vs_d = 1'b0;
	logic    hs_d = 1'b0;
	logic    de_d = 1'b0;
	logic    checking = 1'b0;
	int      arm_req = 0;
	int      arm_ack = 0;
	int      frames_checked = 0;
	rgb333_t line_buf [H_ACTIVE];

	int reset_errors = 0;
	int rdata_errors = 0;
	int pixel_errors = 0;
	int frame_errors = 0;

	video_top #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) DUT (
		.clk       (clk),
		.reset     (reset),
		.cpu       (cpu),
		.cpu_rdata (cpu_rdata),
		.vid_out   (vid_out)
	);

	always #10 clk = ~clk;

	function automatic byte_t random_byte();
		return byte_t'($random(seed));
	endfunction

	task automatic model_write(input logic [CPU_AW-1:0] addr, input byte_t data);
		if (addr < MAP_END) begin
			map_m[addr[MAP_AW-1:0]] = data;
		end else if (addr >= PAT_BASE && addr < PAT_END) begin
			pat_m[addr[PAT_AW-1:0]] = data;
		end else if (addr >= PAL_BASE && addr < PAL_END) begin
			// Even address only latches red bit 2 for the following odd write
			if (addr[0]) begin
				pal_m[addr[PAL_AW:1]] = rgb333_t'({red_hi_m, data});
			end else begin
				red_hi_m = data[0];
			end
		end
	endtask

	function automatic byte_t expected_read(input logic [CPU_AW-1:0] addr);
		byte_t v;
		v = '0;
		if (addr < MAP_END) begin
			v = map_m[addr[MAP_AW-1:0]];
		end else if (addr >= PAT_BASE && addr < PAT_END) begin
			v = pat_m[addr[PAT_AW-1:0]];
		end else if (addr >= PAL_BASE && addr < PAL_END) begin
			if (addr[0]) begin
				v = pal_m[addr[PAL_AW:1]][7:0];
			end else begin
				v = {7'b0, pal_m[addr[PAL_AW:1]].red[2]};
			end
		end
		return v;
	endfunction

	// Output line k shows source row k/2, so line pairs come out identical
	function automatic rgb333_t expected_pixel(input int out_line, input int x);
		int                row;
		byte_t             code;
		byte_t             bits;
		logic [MAP_AW-1:0] map_i;
		logic [2:0]        bit_i;
		row   = out_line / 2;
		map_i = {5'(row / 8), 5'(x / 8)};
		code  = map_m[map_i];
		bits  = pat_m[{code, 3'(row % 8)}];
		bit_i = 3'(7 - x % 8);
		return pal_m[{code[7:3], bits[bit_i]}];
	endfunction

	task automatic bus_write(input logic [CPU_AW-1:0] addr, input byte_t data);
		@(posedge clk);
		cpu <= '{addr: addr, wdata: data, ce: 1'b1, we: 1'b1};
	endtask

	task automatic bus_read(input logic [CPU_AW-1:0] addr);
		@(posedge clk);
		cpu <= '{addr: addr, wdata: 8'h00, ce: 1'b1, we: 1'b0};
	endtask

	task automatic bus_idle();
		@(posedge clk);
		cpu <= '0;
	endtask

	// The doubler has no line to play until the first source line ends
	task automatic check_quiet_start();
		repeat (H_TOTAL) begin
			@(negedge clk);
			assert (!vid_out.de && !vid_out.hsync && !vid_out.vsync) else begin
				$display("MISMATCH at %0t: de/hsync/vsync = %b%b%b after reset, expected 000",
					$time, vid_out.de, vid_out.hsync, vid_out.vsync);
				reset_errors++;
			end
		end
	endtask

	task automatic load_memories();
		int i;
		for (i = 0; i < MAP_WORDS; i++) begin
			bus_write(MAP_BASE + CPU_AW'(i), random_byte());
		end
		for (i = 0; i < PAT_WORDS; i++) begin
			bus_write(PAT_BASE + CPU_AW'(i), random_byte());
		end
		for (i = 0; i < PAL_ENTRIES; i++) begin
			bus_write(PAL_BASE + CPU_AW'(2 * i), random_byte());
			bus_write(PAL_BASE + CPU_AW'(2 * i + 1), random_byte());
		end
	endtask

	task automatic read_back();
		int i;
		for (i = 0; i < MAP_WORDS; i++) begin
			bus_read(MAP_BASE + CPU_AW'(i));
		end
		for (i = 0; i < PAT_WORDS; i++) begin
			bus_read(PAT_BASE + CPU_AW'(i));
		end
		for (i = 0; i < 2 * PAL_ENTRIES; i++) begin
			bus_read(PAL_BASE + CPU_AW'(i));
		end
		// Holes in the address map
		bus_read(13'h0400);
		bus_read(13'h07FF);
		bus_read(13'h1080);
		bus_read(13'h1FFF);
		bus_idle();
	endtask

	// Rewrites visible map entries halfway down the active picture
	task automatic update_map_live();
		int         n;
		logic [4:0] row;
		logic [4:0] col;
		wait (line_cnt == V_ACTIVE);
		for (n = 0; n < 16; n++) begin
			row = 5'({$random(seed)} % (V_ACTIVE / 8));
			col = 5'({$random(seed)} % (H_ACTIVE / 8));
			bus_write(MAP_BASE + {3'b000, row, col}, random_byte());
		end
		bus_idle();
	endtask

	always @(posedge clk) begin
		if (cpu.ce && cpu.we) begin
			model_write(cpu.addr, cpu.wdata);
		end
		taken <= cpu;
	end

	// Read data shows only in the cycle after a read and is zero otherwise
	always @(negedge clk) begin
		byte_t exp_rd;
		exp_rd = '0;
		if (taken.ce && !taken.we) begin
			exp_rd = expected_read(taken.addr);
		end
		if (!reset) begin
			assert (cpu_rdata == exp_rd) else begin
				$display("MISMATCH at %0t: cpu_rdata %h after access to %h, expected %h",
					$time, cpu_rdata, taken.addr, exp_rd);
				rdata_errors++;
			end
		end
	end

	always @(negedge clk) begin
		rgb333_t exp_px;
		if (!reset) begin
			if (vid_out.hsync && !hs_d) begin
				hs_cnt++;
			end
			if (vid_out.vsync && !vs_d) begin
				if (checking) begin
					assert (line_cnt == 2 * V_ACTIVE) else begin
						$display("MISMATCH at %0t: frame has %0d de lines, expected %0d",
							$time, line_cnt, 2 * V_ACTIVE);
						frame_errors++;
					end
					assert (hs_cnt == 2 * V_TOTAL) else begin
						$display("MISMATCH at %0t: frame has %0d hsync pulses, expected %0d",
							$time, hs_cnt, 2 * V_TOTAL);
						frame_errors++;
					end
					frames_checked++;
				end
				checking = (arm_req != arm_ack);
				arm_ack  = arm_req;
				line_cnt = 0;
				hs_cnt   = 0;
			end
			if (vid_out.de) begin
				if (checking && line_cnt < 2 * V_ACTIVE && pix_x < H_ACTIVE) begin
					exp_px = expected_pixel(line_cnt, pix_x);
					assert (vid_out.rgb == exp_px) else begin
						$display("MISMATCH at %0t: line %0d pixel %0d is %h, expected %h",
							$time, line_cnt, pix_x, vid_out.rgb, exp_px);
						pixel_errors++;
					end
					if (line_cnt % 2 == 1) begin
						assert (vid_out.rgb == line_buf[LB_W'(pix_x)]) else begin
							$display("MISMATCH at %0t: line %0d pixel %0d differs from line above",
								$time, line_cnt, pix_x);
							pixel_errors++;
						end
					end
					line_buf[LB_W'(pix_x)] = vid_out.rgb;
				end
				pix_x++;
			end else if (de_d) begin
				if (checking) begin
					assert (pix_x == H_ACTIVE) else begin
						$display("MISMATCH at %0t: line %0d has %0d de pixels, expected %0d",
							$time, line_cnt, pix_x, H_ACTIVE);
						frame_errors++;
					end
				end
				line_cnt++;
				pix_x = 0;
			end
			vs_d = vid_out.vsync;
			hs_d = vid_out.hsync;
			de_d = vid_out.de;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		seed  = 51;
		reset = 1'b1;
		cpu   = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		check_quiet_start();
		load_memories();
		read_back();
		arm_req = arm_req + 1;
		wait (frames_checked == 1);
		update_map_live();
		arm_req = arm_req + 1;
		wait (frames_checked == 2);
		$display("Errors: reset %0d, cpu readback %0d, pixel %0d, frame structure %0d",
			reset_errors, rdata_errors, pixel_errors, frame_errors);
		if (reset_errors + rdata_errors + pixel_errors + frame_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- tile_fetch.sv
// Raster timing and tile lookup for the source picture at pixel rate.
// Walks map, pattern and palette RAMs in a four step pipeline per pixel.

module tile_fetch
	import arcade_video_pkg::*;
#(
	parameter int H_ACTIVE = 256,
	parameter int H_TOTAL  = 384,
	parameter int V_ACTIVE = 224,
	parameter int V_TOTAL  = 264
) (
	input  logic              clk,
	input  logic              reset,
	output logic [MAP_AW-1:0] map_addr,
	input  byte_t             map_q,
	output logic [PAT_AW-1:0] pat_addr,
	input  byte_t             pat_q,
	output logic [PAL_AW-1:0] pal_addr,
	input  rgb333_t           pal_q,
	output logic              pix_ce,
	output video_out_t        src_out
);

	localparam int H_W = $clog2(H_TOTAL);
	localparam int V_W = $clog2(V_TOTAL);

	typedef struct packed {
		logic de;
		logic hsync;
		logic vsync;
	} ctl_t;

	logic [H_W-1:0] h_cnt;
	logic [V_W-1:0] v_cnt;

	logic [4:0] tile_col;
	logic [4:0] tile_row;
	logic [2:0] pix_col;
	logic [2:0] pix_row;
	ctl_t       cur_ctl;

	// Payload carried beside the RAM lookups
	logic [2:0] row_s0;
	logic [2:0] col_s0;
	logic [2:0] col_s1;
	logic [4:0] code_s1;

	// Control bits for the map, pattern and palette address stages
	ctl_t ctl_pipe [3];

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_ce <= 1'b1;
		end else begin
			pix_ce <= !pix_ce;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_ce) begin
			if (h_cnt == H_W'(H_TOTAL - 1)) begin
				h_cnt <= '0;
				if (v_cnt == V_W'(V_TOTAL - 1)) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// The map stride is 32 tiles whatever the active width
	assign tile_col = 5'(h_cnt >> 3);
	assign tile_row = 5'(v_cnt >> 3);
	assign pix_col  = h_cnt[2:0];
	assign pix_row  = v_cnt[2:0];

	always_comb begin
		cur_ctl.de    = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
		cur_ctl.hsync = (h_cnt >= H_ACTIVE + HSYNC_OFFSET) &&
			(h_cnt < H_ACTIVE + HSYNC_OFFSET + HSYNC_WIDTH);
		cur_ctl.vsync = (v_cnt >= V_ACTIVE + VSYNC_OFFSET) &&
			(v_cnt < V_ACTIVE + VSYNC_OFFSET + VSYNC_LINES);
	end

	// RAM reads land one clock after the address, so each lookup result is
	// ready at the next pixel enable
	always_ff @(posedge clk) begin
		if (pix_ce) begin
			map_addr <= {tile_row, tile_col};
			row_s0   <= pix_row;
			col_s0   <= pix_col;

			pat_addr <= {map_q, row_s0};
			code_s1  <= map_q[7:3];
			col_s1   <= col_s0;

			// Pattern MSB is the leftmost pixel
			pal_addr <= {code_s1, pat_q[3'd7 - col_s1]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctl_pipe[0] <= '0;
			ctl_pipe[1] <= '0;
			ctl_pipe[2] <= '0;
			src_out     <= '0;
		end else if (pix_ce) begin
			ctl_pipe[0]   <= cur_ctl;
			ctl_pipe[1]   <= ctl_pipe[0];
			ctl_pipe[2]   <= ctl_pipe[1];
			src_out.rgb   <= ctl_pipe[2].de ? pal_q : '0;
			src_out.de    <= ctl_pipe[2].de;
			src_out.hsync <= ctl_pipe[2].hsync;
			src_out.vsync <= ctl_pipe[2].vsync;
		end
	end

endmodule

//--- video_top.sv
// Video subsystem top: CPU decoder, tile map, pattern and palette RAMs,
// tile fetcher and line doubler. Timing parameters are passed down from here.

module video_top
	import arcade_video_pkg::*;
#(
	parameter int H_ACTIVE = 256,
	parameter int H_TOTAL  = 384,
	parameter int V_ACTIVE = 224,
	parameter int V_TOTAL  = 264
) (
	input  logic       clk,
	input  logic       reset,
	input  cpu_bus_t   cpu,
	output byte_t      cpu_rdata,
	output video_out_t vid_out
);

	map_port_t map_port;
	pat_port_t pat_port;
	pal_port_t pal_port;

	byte_t   map_qa;
	byte_t   pat_qa;
	rgb333_t pal_qa;
	byte_t   map_qb;
	byte_t   pat_qb;
	rgb333_t pal_qb;

	logic [MAP_AW-1:0] map_addr;
	logic [PAT_AW-1:0] pat_addr;
	logic [PAL_AW-1:0] pal_addr;

	logic       pix_ce;
	video_out_t src_out;

	cpu_port_decode decode (
		.clk       (clk),
		.reset     (reset),
		.cpu       (cpu),
		.map_q     (map_qa),
		.pat_q     (pat_qa),
		.pal_q     (pal_qa),
		.map_port  (map_port),
		.pat_port  (pat_port),
		.pal_port  (pal_port),
		.cpu_rdata (cpu_rdata)
	);

	// Port A belongs to the CPU, port B is a read-only video port
	dpram #(.ADDR_W(MAP_AW), .word_t(byte_t)) map_ram (
		.clk       (clk),
		.address_a (map_port.addr),
		.data_a    (map_port.data),
		.enable_a  (map_port.ce),
		.wren_a    (map_port.we),
		.q_a       (map_qa),
		.address_b (map_addr),
		.data_b    ('0),
		.enable_b  (1'b1),
		.wren_b    (1'b0),
		.q_b       (map_qb)
	);

	dpram #(.ADDR_W(PAT_AW), .word_t(byte_t)) pat_ram (
		.clk       (clk),
		.address_a (pat_port.addr),
		.data_a    (pat_port.data),
		.enable_a  (pat_port.ce),
		.wren_a    (pat_port.we),
		.q_a       (pat_qa),
		.address_b (pat_addr),
		.data_b    ('0),
		.enable_b  (1'b1),
		.wren_b    (1'b0),
		.q_b       (pat_qb)
	);

	dpram #(.ADDR_W(PAL_AW), .word_t(rgb333_t)) pal_ram (
		.clk       (clk),
		.address_a (pal_port.addr),
		.data_a    (pal_port.data),
		.enable_a  (pal_port.ce),
		.wren_a    (pal_port.we),
		.q_a       (pal_qa),
		.address_b (pal_addr),
		.data_b    ('0),
		.enable_b  (1'b1),
		.wren_b    (1'b0),
		.q_b       (pal_qb)
	);

	tile_fetch #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) fetch (
		.clk      (clk),
		.reset    (reset),
		.map_addr (map_addr),
		.map_q    (map_qb),
		.pat_addr (pat_addr),
		.pat_q    (pat_qb),
		.pal_addr (pal_addr),
		.pal_q    (pal_qb),
		.pix_ce   (pix_ce),
		.src_out  (src_out)
	);

	line_doubler #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL)
	) doubler (
		.clk     (clk),
		.reset   (reset),
		.pix_ce  (pix_ce),
		.src_out (src_out),
		.vid_out (vid_out)
	);

endmodule
